// File: motion_cfg_pkg.sv
`default_nettype none

package motion_cfg_pkg;

  // Move ring buffer geometry
  localparam int MOVE_BUFFER_BITS  = 2;                     // Slot index width
  localparam int MOVE_BUFFER_DEPTH = 1 << MOVE_BUFFER_BITS; // Four slots

  // Segment field widths
  localparam int DURATION_BITS = 32; // Ticks per segment
  localparam int RATE_BITS     = 64; // Increment and accumulator
  localparam int TICK_DIV_BITS = 16; // Prescaler divider

  // Substep rollback per step taken
  // Just under the signed maximum, leaves headroom before overflow
  localparam logic signed [RATE_BITS-1:0] STEP_THRESHOLD =
    64'sh7fff_ffff_ffff_ff9b;

  // Driver pulse width in clock cycles
  localparam int STEP_PULSE_CYCLES = 4;
  localparam int STEP_PULSE_BITS   = $clog2(STEP_PULSE_CYCLES + 1); // Holds 0..width

endpackage

`default_nettype wire

// File: motion_types_pkg.sv
`default_nettype none

package motion_types_pkg;

  // Vectors with a meaning of their own
  typedef logic [motion_cfg_pkg::MOVE_BUFFER_BITS-1:0]  move_idx_t;   // Ring slot index
  typedef logic [motion_cfg_pkg::MOVE_BUFFER_DEPTH-1:0] slot_flags_t; // One bit per slot
  typedef logic [motion_cfg_pkg::DURATION_BITS-1:0]     duration_t;   // Segment length
  typedef logic signed [motion_cfg_pkg::RATE_BITS-1:0]  rate_t;       // Per-tick rate
  typedef logic [motion_cfg_pkg::TICK_DIV_BITS-1:0]     tick_div_t;   // Tick prescale
  typedef logic [motion_cfg_pkg::STEP_PULSE_BITS-1:0]   pulse_cnt_t;  // Pulse width count

  // One move segment, 160 bits
  typedef struct packed {
    duration_t duration;           // DDA ticks minus one
    rate_t     increment;          // Starting rate
    rate_t     incrementincrement; // Rate change per tick
  } move_t;

  // Host side write port
  typedef struct packed {
    logic  strobe; // Write request, one cycle
    move_t move;
  } host_wr_t;

  // Timer sequencing
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    EXECUTE
  } dda_state_e;

endpackage

`default_nettype wire

// File: move_buffer.sv
`default_nettype none

module move_buffer (
  input  wire                           CLK,
  input  wire                           resetn,
  input  wire motion_types_pkg::host_wr_t    host_wr,
  input  wire motion_types_pkg::move_idx_t   moveind,      // Timer read cursor
  input  wire motion_types_pkg::slot_flags_t stepfinished, // Toggled by timer
  output motion_types_pkg::move_t            cur_move,
  output motion_types_pkg::slot_flags_t      stepready,
  output motion_types_pkg::move_idx_t        writemoveind,
  output logic                               buffer_full
);

  // Segment storage, no reset on payload
  motion_types_pkg::move_t slots [motion_cfg_pkg::MOVE_BUFFER_DEPTH];

  logic wr_accept; // Write taken this cycle

  // Slot under write cursor still waiting on the timer
  // Four pending slots means the ring is full
  assign buffer_full = stepready[writemoveind] ^ stepfinished[writemoveind];

  // Strobe while full is dropped
  assign wr_accept = host_wr.strobe && !buffer_full;

  // Combinational read port for the timer and accumulator
  assign cur_move = slots[moveind];

  always_ff @(posedge CLK) begin
    if (wr_accept) begin
      slots[writemoveind] <= host_wr.move;
    end
  end

  // Cursor and ready toggles
  always_ff @(posedge CLK) begin
    if (resetn) begin
      writemoveind <= '0;
      stepready    <= '0;
    end else if (wr_accept) begin
      stepready[writemoveind] <= ~stepready[writemoveind]; // Slot now pending
      writemoveind <= writemoveind + motion_types_pkg::move_idx_t'(1); // Wraps at depth
    end
  end

endmodule

`default_nettype wire

// File: dda_tick_gen.sv
`default_nettype none

module dda_tick_gen (
  input  wire                             CLK,
  input  wire                             resetn,
  input  wire motion_types_pkg::tick_div_t tick_div, // Period minus one
  output logic                            dda_tick
);

  motion_types_pkg::tick_div_t cnt; // Cycles left until next tick

  // Down-counter, tick_div only sampled when it wraps
  always_ff @(posedge CLK) begin
    if (resetn) begin
      cnt      <= '0;
      dda_tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt      <= tick_div; // Reload
      dda_tick <= 1'b1;
    end else begin
      cnt      <= cnt - motion_types_pkg::tick_div_t'(1);
      dda_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: dda_timer.sv
`default_nettype none

module dda_timer (
  input  wire                               CLK,
  input  wire                               resetn,
  input  wire motion_types_pkg::move_t      cur_move,
  input  wire motion_types_pkg::slot_flags_t stepready,
  input  wire motion_types_pkg::move_idx_t  writemoveind,
  input  wire                               dda_tick,
  input  wire                               halt,        // Active low
  output motion_types_pkg::move_idx_t       moveind,
  output motion_types_pkg::slot_flags_t     stepfinished,
  output logic                              load,
  output logic                              accum_enable,
  output logic                              move_done   // Alternates per segment
);

  motion_types_pkg::dda_state_e state;
  motion_types_pkg::duration_t  tickdowncount; // Ticks left in segment

  logic       pending;  // Slot at read cursor awaits execution
  logic       seg_end;  // Last tick of the segment
  logic       seg_done; // Registered completion pulse
  logic [1:0] done_sr;  // Edge detector stages

  assign pending = stepready[moveind] ^ stepfinished[moveind];

  // Halt takes priority so nothing reaches the accumulator that cycle
  assign load         = (state == motion_types_pkg::LOAD) && halt;
  assign accum_enable = (state == motion_types_pkg::EXECUTE) && dda_tick && halt;
  assign seg_end      = accum_enable && (tickdowncount == '0);

  // Segment sequencing
  always_ff @(posedge CLK) begin
    if (resetn) begin
      state        <= motion_types_pkg::IDLE;
      moveind      <= '0;
      stepfinished <= '0;
      seg_done     <= 1'b0;
    end else begin
      seg_done <= seg_end;
      if (!halt) begin
        // Drop everything queued
        moveind      <= writemoveind;
        stepfinished <= stepready;
        state        <= motion_types_pkg::IDLE;
      end else begin
        case (state)
          motion_types_pkg::IDLE: begin
            if (pending) state <= motion_types_pkg::LOAD;
          end
          motion_types_pkg::LOAD: begin
            state <= motion_types_pkg::EXECUTE; // Duration captured below
          end
          motion_types_pkg::EXECUTE: begin
            if (seg_end) begin
              stepfinished[moveind] <= ~stepfinished[moveind]; // Hand slot back
              moveind <= moveind + motion_types_pkg::move_idx_t'(1);
              state   <= motion_types_pkg::IDLE;
            end
          end
          default: state <= motion_types_pkg::IDLE;
        endcase
      end
    end
  end

  // Tick count, D+1 ticks per segment
  always_ff @(posedge CLK) begin
    if (load) begin
      tickdowncount <= cur_move.duration;
    end else if (accum_enable && !seg_end) begin
      tickdowncount <= tickdowncount - motion_types_pkg::duration_t'(1);
    end
  end

  // Rising edge of seg_done flips move_done
  always_ff @(posedge CLK) begin
    if (resetn) begin
      done_sr   <= 2'b00;
      move_done <= 1'b0;
    end else begin
      done_sr <= {done_sr[0], seg_done};
      if (done_sr == 2'b01) move_done <= ~move_done;
    end
  end

endmodule

`default_nettype wire

// File: dda_accumulator.sv
`default_nettype none

module dda_accumulator (
  input  wire                          CLK,
  input  wire                          resetn,
  input  wire                          load,         // Start of segment
  input  wire motion_types_pkg::move_t cur_move,
  input  wire                          accum_enable, // One per DDA tick
  output logic                         step_raw
);

  motion_types_pkg::rate_t increment_r; // Running rate, loaded per segment
  motion_types_pkg::rate_t accum;       // Substep position, carried over

  logic                    take_step;
  motion_types_pkg::rate_t rollback;

  // Decision uses the value before this tick
  assign take_step = accum > motion_types_pkg::rate_t'(0);
  assign rollback  = take_step ? motion_cfg_pkg::STEP_THRESHOLD
                               : motion_types_pkg::rate_t'(0);

  // Running increment
  always_ff @(posedge CLK) begin
    if (load) begin
      increment_r <= cur_move.increment;
    end else if (accum_enable) begin
      increment_r <= increment_r + cur_move.incrementincrement; // Constant accel
    end
  end

  // Accumulator survives halt and segment changes
  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum    <= '0;
      step_raw <= 1'b0;
    end else if (accum_enable) begin
      accum    <= accum + increment_r - rollback;
      step_raw <= take_step;
    end else begin
      step_raw <= 1'b0; // Single cycle
    end
  end

endmodule

`default_nettype wire

// File: step_pulse_shaper.sv
`default_nettype none

module step_pulse_shaper (
  input  wire  CLK,
  input  wire  resetn,
  input  wire  step_raw, // One cycle step decision
  output logic step      // To motor driver
);

  motion_types_pkg::pulse_cnt_t width_cnt; // Cycles of pulse left

  // New decision restarts the count
  always_ff @(posedge CLK) begin
    if (resetn) begin
      width_cnt <= '0;
    end else if (step_raw) begin
      width_cnt <= motion_types_pkg::pulse_cnt_t'(motion_cfg_pkg::STEP_PULSE_CYCLES);
    end else if (width_cnt != '0) begin
      width_cnt <= width_cnt - motion_types_pkg::pulse_cnt_t'(1);
    end
  end

  // High from the cycle after step_raw
  assign step = (width_cnt != '0);

endmodule

`default_nettype wire

// File: stepper_axis_top.sv
`default_nettype none

module stepper_axis_top (
  input  wire                              CLK,
  input  wire                              resetn,
  input  wire motion_types_pkg::host_wr_t  host_wr,
  input  wire motion_types_pkg::tick_div_t tick_div,
  input  wire                              halt,
  output logic                             buffer_full,
  output logic                             step,
  output logic                             move_done
);

  motion_types_pkg::move_t       cur_move;     // Segment at read cursor
  motion_types_pkg::slot_flags_t stepready;
  motion_types_pkg::slot_flags_t stepfinished;
  motion_types_pkg::move_idx_t   writemoveind;
  motion_types_pkg::move_idx_t   moveind;
  logic dda_tick;
  logic load;
  logic accum_enable;
  logic step_raw;

  move_buffer buffer_i (
    .CLK(CLK), .resetn(resetn), .host_wr(host_wr), .moveind(moveind),
    .stepfinished(stepfinished), .cur_move(cur_move), .stepready(stepready),
    .writemoveind(writemoveind), .buffer_full(buffer_full)
  );

  dda_tick_gen tick_i (.CLK(CLK), .resetn(resetn), .tick_div(tick_div), .dda_tick(dda_tick));

  dda_timer timer_i (
    .CLK(CLK), .resetn(resetn), .cur_move(cur_move), .stepready(stepready),
    .writemoveind(writemoveind), .dda_tick(dda_tick), .halt(halt), .moveind(moveind),
    .stepfinished(stepfinished), .load(load), .accum_enable(accum_enable),
    .move_done(move_done)
  );

  dda_accumulator accum_i (
    .CLK(CLK), .resetn(resetn), .load(load), .cur_move(cur_move),
    .accum_enable(accum_enable), .step_raw(step_raw)
  );

  step_pulse_shaper shaper_i (.CLK(CLK), .resetn(resetn), .step_raw(step_raw), .step(step));

endmodule

`default_nettype wire

// File: stepper_axis_checker.sv
`default_nettype none

module stepper_axis_checker (
  input wire                                CLK,
  input wire                                resetn,
  input wire                                wr_strobe,
  input wire                                buffer_full,
  input wire motion_types_pkg::move_idx_t   writemoveind,
  input wire motion_types_pkg::slot_flags_t stepready,
  input wire motion_types_pkg::slot_flags_t stepfinished,
  input wire                                step_raw,
  input wire                                step,
  input wire                                move_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0; // Failed assertions so far
  logic        buf_empty;        // No slot pending anywhere

  assign buf_empty = (stepready == stepfinished);

  // Outputs held low through reset
  reset_state_a: assert property (@(posedge CLK)
    $past(resetn) |-> !step && !move_done && !buffer_full)
    else begin
      assert_fails++;
      $error("outputs not low after reset");
    end

  // Last pulse of a segment needs two cycles to surface
  idle_no_step_a: assert property (@(posedge CLK) disable iff (resetn)
    buf_empty && $past(buf_empty) && $past(buf_empty, 2) |-> !$rose(step))
    else begin
      assert_fails++;
      $error("step pulse with empty buffer");
    end

  step_follows_raw_a: assert property (@(posedge CLK) disable iff (resetn)
    $rose(step) |-> $past(step_raw))
    else begin
      assert_fails++;
      $error("step rose without step_raw");
    end

  // Four samples high before the fall, matches STEP_PULSE_CYCLES
  pulse_width_a: assert property (@(posedge CLK) disable iff (resetn)
    $fell(step) |-> $past(step, 1) && $past(step, 2) && $past(step, 3) && $past(step, 4))
    else begin
      assert_fails++;
      $error("step pulse shorter than driver minimum");
    end

  full_drop_a: assert property (@(posedge CLK) disable iff (resetn)
    wr_strobe && buffer_full |=> $stable(writemoveind))
    else begin
      assert_fails++;
      $error("write accepted while buffer full");
    end

endmodule

bind stepper_axis_top stepper_axis_checker checker_i (
  .CLK(CLK), .resetn(resetn), .wr_strobe(host_wr.strobe), .buffer_full(buffer_full),
  .writemoveind(writemoveind), .stepready(stepready), .stepfinished(stepfinished),
  .step_raw(step_raw), .step(step), .move_done(move_done)
);

`default_nettype wire

// File: stepper_axis_tb.sv
`default_nettype none

module stepper_axis_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                        CLK;
  logic                        resetn;
  motion_types_pkg::host_wr_t  host_wr;
  motion_types_pkg::tick_div_t tick_div;
  logic                        halt;
  logic                        buffer_full;
  logic                        step;
  logic                        move_done;

  motion_types_pkg::move_t seg;         // Segment being built
  motion_types_pkg::rate_t model_acc;   // Expected substep accumulator
  int unsigned             step_cnt;    // Step rising edges since reset
  int unsigned             done_cnt;    // move_done toggles since reset
  int unsigned             exp_steps;
  int unsigned             exp_done;
  int unsigned             errors;
  logic                    step_q;
  logic                    done_q;
  longint                  cycle_cnt = 0;
  longint                  cycle_limit = 2000; // Grows with each written segment

  stepper_axis_top dut_i (.CLK(CLK), .resetn(resetn), .host_wr(host_wr), .tick_div(tick_div),
    .halt(halt), .buffer_full(buffer_full), .step(step), .move_done(move_done));

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // Sampled before the edge updates
  always @(posedge CLK) begin
    if (resetn) begin
      step_cnt <= 0;
      done_cnt <= 0;
    end else begin
      if (step && !step_q) step_cnt <= step_cnt + 1;
      if (move_done != done_q) done_cnt <= done_cnt + 1;
    end
    step_q <= step;
    done_q <= move_done;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic apply_reset();
    resetn = 1'b1;
    repeat (4) @(negedge CLK);
    resetn = 1'b0;
    model_acc = '0; // Accumulator clears only here
    exp_steps = 0;
    exp_done = 0;
  endtask

  // Step rule applied over D+1 ticks
  task automatic model_move(input motion_types_pkg::move_t m);
    motion_types_pkg::rate_t inc;
    inc = m.increment;
    for (longint t = 0; t <= longint'(m.duration); t++) begin
      if (model_acc > motion_types_pkg::rate_t'(0)) begin
        model_acc = model_acc + inc - motion_cfg_pkg::STEP_THRESHOLD;
        exp_steps++;
      end else begin
        model_acc = model_acc + inc;
      end
      inc = inc + m.incrementincrement;
    end
    exp_done++;
  endtask

  task automatic send_move(input motion_types_pkg::move_t m, input bit accepted);
    host_wr.strobe = 1'b1;
    host_wr.move = m;
    @(negedge CLK);
    host_wr.strobe = 1'b0;
    cycle_limit += (longint'(m.duration) + 2) * (longint'(tick_div) + 1);
    if (accepted) model_move(m);
  endtask

  function automatic motion_types_pkg::move_t random_move();
    motion_types_pkg::move_t m;
    logic [31:0]             r;
    r = $urandom % 32'h0100_0000;
    m.duration = 5 + $urandom % 36;
    m.increment = 64'h0800_0000_0000_0000; // About one step per 16 ticks
    m.incrementincrement = {r, 32'h0};
    return m;
  endfunction

  task automatic wait_done(input int unsigned n);
    while (done_cnt < n) @(negedge CLK);
    repeat (10) @(negedge CLK); // Room for a stray late pulse
  endtask

  task automatic check_value(input string name, input longint got, input longint exp);
    assert (got == exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_counts(input string name);
    check_value({name, " step rising edges"}, step_cnt, exp_steps);
    check_value({name, " move_done toggles"}, done_cnt, exp_done);
  endtask

  initial begin
    void'($urandom(32'h9f15));
    resetn = 1'b1;
    host_wr = '0;
    tick_div = '0;
    halt = 1'b1;
    errors = 0;

    // Constant rate
    tick_div = motion_types_pkg::tick_div_t'(1);
    apply_reset();
    seg.duration = 30;
    seg.increment = 64'h2000_0000_0000_0000;
    seg.incrementincrement = '0;
    send_move(seg, 1'b1);
    wait_done(1);
    compare_counts("constant");

    // Accelerating runs carry the accumulator across segments
    tick_div = motion_types_pkg::tick_div_t'(3);
    apply_reset();
    repeat (4) send_move(random_move(), 1'b1);
    wait_done(4);
    compare_counts("accel div3");
    tick_div = motion_types_pkg::tick_div_t'(2 + $urandom % 6); // Keeps step pulses apart
    apply_reset();
    repeat (4) send_move(random_move(), 1'b1);
    wait_done(4);
    compare_counts("accel random div");

    // Fifth write into a full ring is lost
    tick_div = motion_types_pkg::tick_div_t'(40);
    apply_reset();
    seg = random_move();
    seg.duration = 3;
    repeat (4) send_move(seg, 1'b1);
    check_value("buffer_full", buffer_full, 1);
    send_move(seg, 1'b0);
    wait_done(4);
    repeat (5 * 41) @(negedge CLK); // One segment time for a wrongly kept write
    compare_counts("full");

    // Halt mid run with the ring full again
    tick_div = motion_types_pkg::tick_div_t'(10);
    apply_reset();
    seg.duration = 20;
    repeat (4) send_move(seg, 1'b1);
    while (done_cnt < 1) @(negedge CLK);
    send_move(seg, 1'b1); // Refills the slot just freed
    check_value("buffer_full", buffer_full, 1);
    repeat (5) @(negedge CLK);
    halt = 1'b0;
    @(negedge CLK);
    halt = 1'b1;
    check_value("buffer_full", buffer_full, 0);
    repeat (2 * 22 * 11) @(negedge CLK);
    check_value("halt move_done toggles", done_cnt, 1);
    send_move(seg, 1'b1);
    wait_done(2);
    check_value("post halt move_done toggles", done_cnt, 2);

    $display("Summary: %0d count errors, %0d assertion failures",
      errors, dut_i.checker_i.assert_fails);
    if (errors == 0 && dut_i.checker_i.assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: stepper_axis_top.f
motion_cfg_pkg.sv
motion_types_pkg.sv
move_buffer.sv
dda_tick_gen.sv
dda_timer.sv
dda_accumulator.sv
step_pulse_shaper.sv
stepper_axis_top.sv
stepper_axis_checker.sv
stepper_axis_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stepper axis testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module stepper_axis_tb -f stepper_axis_top.f; then
  echo "Verilator build failed"
  exit 1
fi

# Keep going past assertion errors so the testbench can report them
sim_out=$(./obj_dir/Vstepper_axis_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1
